/* src/line_cache_defs.svh */
`ifndef LINE_CACHE_DEFS_SVH
`define LINE_CACHE_DEFS_SVH

// **************************************************
// address and data geometry
// **************************************************

`define LC_ALEN         43 // byte address width
`define LC_DATA_W       64 // one line holds one 64-bit word
`define LC_ALIGN_BITS   3  // low address bits that must be zero

// **************************************************
// line layout, entry is | tag | data |
// **************************************************

`define LC_INDEX_W      8  // 256 lines
`define LC_TAG_W        (`LC_ALEN - `LC_ALIGN_BITS - `LC_INDEX_W) // 32 with the values above
`define LC_ENTRY_W      (`LC_TAG_W + `LC_DATA_W) // 96 bits per stored line

// **************************************************
// block RAM geometry
// **************************************************

`define LC_BRAM_DATA_W  16 // one 4 kbit block, 16 bits wide
`define LC_BRAM_BLOCKS  (`LC_ENTRY_W / `LC_BRAM_DATA_W) // blocks needed per line

// hit and miss counter width
`define LC_CNT_W        16

`endif

/* src/line_cache_pkg.sv */
`include "line_cache_defs.svh"

package line_cache_pkg;

	// **************************************************
	// command opcodes
	// **************************************************

	typedef enum logic [1:0] {
		op_nop       = 2'd0, // idle or a dropped misaligned write
		op_read      = 2'd1, // lookup, returns data and hit
		op_write     = 2'd2, // fills the line at the index
		op_inval_all = 2'd3  // clears every valid bit
	} lc_op_e;

	// raw command as it arrives at the top level
	typedef struct packed {
		lc_op_e                   op;
		logic [`LC_ALEN-1:0]      addr;
		logic [`LC_DATA_W-1:0]    wdata;
	} lc_cmd_t;

	// decoded command, address already split
	typedef struct packed {
		lc_op_e                   op;
		logic [`LC_TAG_W-1:0]     tag;
		logic [`LC_INDEX_W-1:0]   index;
		logic [`LC_DATA_W-1:0]    wdata;
		logic                     misaligned; // low address bits were not zero
	} lc_lookup_t;

	// response for reads and for rejected accesses
	typedef struct packed {
		logic                     valid;
		logic                     hit;
		logic                     error;
		logic [`LC_DATA_W-1:0]    rdata; // zero unless hit
	} lc_rsp_t;

endpackage

/* src/cmd_decode.sv */
`timescale 1ns/1ps
`include "line_cache_defs.svh"

module cmd_decode import line_cache_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       cmd_valid,
	input  lc_cmd_t    cmd,
	output logic       lk_valid,
	output lc_lookup_t lk
);

	logic   misalign_d;
	lc_op_e op_d;

	// **************************************************
	// alignment check
	// **************************************************

	always_comb begin
		// only reads and writes carry a meaningful address
		misalign_d = (cmd.addr[`LC_ALIGN_BITS-1:0] != '0) &&
			(cmd.op == op_read || cmd.op == op_write);
		op_d = cmd.op;
		if (misalign_d && cmd.op == op_write)
			op_d = op_nop; // cache stays untouched, error flag still travels
	end

	// **************************************************
	// command register
	// **************************************************

	always_ff @(posedge clk) begin
		if (rst)
			lk_valid <= 1'b0;
		else
			lk_valid <= cmd_valid;
	end

	always_ff @(posedge clk) begin
		lk.op         <= op_d;
		lk.tag        <= cmd.addr[`LC_ALEN-1 -: `LC_TAG_W]; // upper bits
		lk.index      <= cmd.addr[`LC_ALIGN_BITS +: `LC_INDEX_W]; // bits just above alignment
		lk.wdata      <= cmd.wdata;
		lk.misaligned <= misalign_d;
	end

endmodule

/* src/line_bram.sv */
`timescale 1ns/1ps
`include "line_cache_defs.svh"

module line_bram #(
	parameter int addr_width = 8,
	parameter int data_width = 96
) (
	input  logic                  clk,
	input  logic                  we,
	input  logic [addr_width-1:0] waddr,
	input  logic [addr_width-1:0] raddr,
	input  logic [data_width-1:0] wdata,
	output logic [data_width-1:0] rdata
);

	localparam int blk_w = `LC_BRAM_DATA_W;
	localparam int n_blk = (data_width + blk_w - 1) / blk_w; // last block may be narrower
	localparam int depth = 1 << addr_width;

	genvar b;

	// **************************************************
	// one memory per block, shared write enable
	// **************************************************

	generate
		for (b = 0; b < n_blk; b++) begin : g_blk
			localparam int lo = b * blk_w;
			localparam int w  = (data_width - lo < blk_w) ? (data_width - lo) : blk_w;

			logic [w-1:0] mem [depth];
			logic [w-1:0] rd_q;

			always_ff @(posedge clk) begin
				if (we)
					mem[waddr] <= wdata[lo +: w];
				rd_q <= mem[raddr]; // registered read, old data on a same-address write
			end

			assign rdata[lo +: w] = rd_q;
		end
	endgenerate

endmodule

/* src/basic_cache.sv */
`timescale 1ns/1ps
`include "line_cache_defs.svh"

// direct-mapped cache, one 64-bit word per line
// each line is stored as | tag | data | in the line RAM
module basic_cache import line_cache_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  lk_valid,
	input  lc_lookup_t            lk,
	output logic                  hit,
	output logic [`LC_DATA_W-1:0] rdata
);

	logic                         we;
	logic                         inval;
	logic [`LC_ENTRY_W-1:0]       line_wdata;
	logic [`LC_ENTRY_W-1:0]       line_rdata;
	logic [(1<<`LC_INDEX_W)-1:0]  valid_bits;
	logic                         valid_q; // valid bit of the line being read
	logic [`LC_TAG_W-1:0]         tag_q;   // tag of the lookup being read
	logic [`LC_TAG_W-1:0]         entry_tag;

	// **************************************************
	// command decode
	// **************************************************

	assign we    = lk_valid && (lk.op == op_write); // misaligned writes arrive as nop
	assign inval = lk_valid && (lk.op == op_inval_all);

	assign line_wdata = {lk.tag, lk.wdata};

	// **************************************************
	// line storage
	// **************************************************

	line_bram #(
		.addr_width (`LC_INDEX_W),
		.data_width (`LC_BRAM_BLOCKS * `LC_BRAM_DATA_W)
	) u_bram (
		.clk   (clk),
		.we    (we),
		.waddr (lk.index),
		.raddr (lk.index), // read every cycle, used only for reads
		.wdata (line_wdata),
		.rdata (line_rdata)
	);

	// **************************************************
	// valid bits
	// **************************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_bits <= '0;
			valid_q    <= 1'b0;
		end else begin
			if (inval)
				valid_bits <= '0;
			else if (we)
				valid_bits[lk.index] <= 1'b1;
			valid_q <= valid_bits[lk.index]; // lines up with the RAM read
		end
	end

	// tag follows the lookup every cycle so the compare matches the RAM output
	always_ff @(posedge clk) begin
		tag_q <= lk.tag;
	end

	// **************************************************
	// tag compare
	// **************************************************

	assign entry_tag = line_rdata[`LC_DATA_W +: `LC_TAG_W];
	assign hit       = valid_q && (entry_tag == tag_q);
	assign rdata     = line_rdata[0 +: `LC_DATA_W];

endmodule

/* src/result_stage.sv */
`timescale 1ns/1ps
`include "line_cache_defs.svh"

module result_stage import line_cache_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  lk_valid,
	input  lc_lookup_t            lk,
	input  logic                  hit,
	input  logic [`LC_DATA_W-1:0] rdata,
	output lc_rsp_t               rsp,
	output logic [`LC_CNT_W-1:0]  hit_count,
	output logic [`LC_CNT_W-1:0]  miss_count
);

	logic    vld_q;
	lc_op_e  op_q;
	logic    err_q;
	logic    rd_ok; // aligned read, counts toward the totals
	lc_rsp_t rsp_d;

	// **************************************************
	// delay to match the cache read
	// **************************************************

	always_ff @(posedge clk) begin
		if (rst)
			vld_q <= 1'b0;
		else
			vld_q <= lk_valid;
	end

	always_ff @(posedge clk) begin
		op_q  <= lk.op;
		err_q <= lk.misaligned;
	end

	always_comb begin
		rd_ok       = vld_q && (op_q == op_read) && !err_q;
		rsp_d.valid = vld_q && ((op_q == op_read) || err_q);
		rsp_d.hit   = rd_ok && hit;
		rsp_d.error = vld_q && err_q;
		rsp_d.rdata = (rd_ok && hit) ? rdata : '0; // no stale line data on a miss
	end

	// **************************************************
	// response and counters
	// **************************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			rsp        <= '0;
			hit_count  <= '0;
			miss_count <= '0;
		end else begin
			rsp <= rsp_d;
			if (rd_ok && hit && hit_count != '1)
				hit_count <= hit_count + 1'b1; // saturates at all ones
			if (rd_ok && !hit && miss_count != '1)
				miss_count <= miss_count + 1'b1;
		end
	end

endmodule

/* src/line_cache_top.sv */
`timescale 1ns/1ps
`include "line_cache_defs.svh"

// decode -> cache -> result, three register stages from cmd to rsp
module line_cache_top import line_cache_pkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 cmd_valid,
	input  lc_cmd_t              cmd,
	output lc_rsp_t              rsp,
	output logic [`LC_CNT_W-1:0] hit_count,
	output logic [`LC_CNT_W-1:0] miss_count
);

	logic                  lk_valid;
	lc_lookup_t            lk;
	logic                  line_rdata_hit;
	logic [`LC_DATA_W-1:0] rdata;

	cmd_decode u_decode (
		.clk       (clk),
		.rst       (rst),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.lk_valid  (lk_valid),
		.lk        (lk)
	);

	basic_cache u_cache (
		.clk      (clk),
		.rst      (rst),
		.lk_valid (lk_valid),
		.lk       (lk),
		.hit      (line_rdata_hit),
		.rdata    (rdata)
	);

	result_stage u_result (
		.clk        (clk),
		.rst        (rst),
		.lk_valid   (lk_valid),
		.lk         (lk),
		.hit        (line_rdata_hit),
		.rdata      (rdata),
		.rsp        (rsp),
		.hit_count  (hit_count),
		.miss_count (miss_count)
	);

endmodule

/* tests/line_cache_tb.sv */
`timescale 1ns/1ps
`include "line_cache_defs.svh"

module line_cache_tb import line_cache_pkg::*; ();

	typedef struct packed {
		lc_op_e                op;
		logic [`LC_ALEN-1:0]   addr;
		logic [`LC_DATA_W-1:0] data;
		logic                  exp_hit; // only meaningful for aligned reads
	} stim_t;

	localparam int n_lines     = 1 << `LC_INDEX_W;
	localparam int rsp_timeout = 10; // cycles a read may wait for rsp.valid

	logic                 clk;
	logic                 rst;
	logic                 cmd_valid;
	lc_cmd_t              cmd;
	lc_rsp_t              rsp;
	logic [`LC_CNT_W-1:0] hit_count;
	logic [`LC_CNT_W-1:0] miss_count;

	stim_t                 tbl[$];
	lc_rsp_t               exp_q[$];
	int                    issue_q[$]; // issue cycle of each expected response
	logic                  mdl_valid [n_lines];
	logic [`LC_TAG_W-1:0]  mdl_tag [n_lines];
	logic [`LC_DATA_W-1:0] mdl_data [n_lines];
	int                    cyc;
	int                    errors;
	int                    n_checks;
	int                    n_hit;
	int                    n_miss;
	logic                  timed_out;
	logic [31:0]           lfsr_state;

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	line_cache_top u_line_cache_top (
		.clk        (clk),
		.rst        (rst),
		.cmd_valid  (cmd_valid),
		.cmd        (cmd),
		.rsp        (rsp),
		.hit_count  (hit_count),
		.miss_count (miss_count)
	);

	// **************************************************
	// helpers
	// **************************************************

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // x^32 + x^22 + x^2 + x + 1
	endfunction

	function automatic logic [63:0] rand_word();
		logic [63:0] v;
		v = '0;
		for (int k = 0; k < 64; k++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[62:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic logic [`LC_ALEN-1:0] line_addr(input logic [`LC_TAG_W-1:0] tag,
		input logic [`LC_INDEX_W-1:0] idx, input logic [`LC_ALIGN_BITS-1:0] low);
		return {tag, idx, low}; // tag on top, index above the byte offset
	endfunction

	task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
		n_checks++;
		if (exp !== act) begin
			errors++;
			$display("CHECK FAILED at %0t: %s expected %0h actual %0h", $time, name, exp, act);
		end
	endtask

	task automatic add_entry(input lc_op_e op, input logic [`LC_ALEN-1:0] addr,
		input logic [`LC_DATA_W-1:0] data, input logic exp_hit);
		tbl.push_back({op, addr, data, exp_hit});
	endtask

	// **************************************************
	// stimulus table
	// **************************************************

	task automatic build_table();
		logic [`LC_ALEN-1:0] a_a;
		logic [`LC_ALEN-1:0] a_b;
		logic [`LC_ALEN-1:0] a_c;
		logic [`LC_ALEN-1:0] a_d;
		logic [`LC_ALEN-1:0] a_e;
		a_a = line_addr(32'h0000_1234, 8'h05, 3'd0);
		a_b = line_addr(32'hdead_beef, 8'h10, 3'd0);
		a_c = line_addr(32'h0000_5678, 8'h05, 3'd0); // same index as a_a
		a_d = line_addr(32'h0000_0001, 8'h10, 3'd0); // same index as a_b
		a_e = line_addr(32'h0abc_0000, 8'h20, 3'd0);
		add_entry(op_read, line_addr(32'h0, 8'h00, 3'd0), 64'd0, 1'b0); // empty after reset
		add_entry(op_read, a_a, 64'd0, 1'b0);
		add_entry(op_read, line_addr(32'hffff_ffff, 8'hff, 3'd0), 64'd0, 1'b0);
		add_entry(op_write, a_a, rand_word(), 1'b0);
		add_entry(op_read, a_a, 64'd0, 1'b1); // very next cycle
		add_entry(op_write, a_b, 64'h0123_4567_89ab_cdef, 1'b0);
		add_entry(op_nop, '0, 64'd0, 1'b0);
		add_entry(op_read, a_b, 64'd0, 1'b1);
		add_entry(op_write, a_c, 64'hfeed_face_cafe_f00d, 1'b0); // evicts a_a
		add_entry(op_read, a_a, 64'd0, 1'b0);
		add_entry(op_read, a_c, 64'd0, 1'b1);
		add_entry(op_inval_all, '0, 64'd0, 1'b0);
		add_entry(op_read, a_c, 64'd0, 1'b0);
		add_entry(op_read, a_b, 64'd0, 1'b0);
		add_entry(op_write, a_d, rand_word(), 1'b0);
		add_entry(op_read, a_d, 64'd0, 1'b1);
		add_entry(op_read, a_d | 43'd3, 64'd0, 1'b0); // unaligned
		add_entry(op_write, a_d | 43'd4, 64'h0000_0000_0bad_0bad, 1'b0);
		add_entry(op_read, a_d, 64'd0, 1'b1); // old data survives
		add_entry(op_write, a_e, rand_word(), 1'b0);
		add_entry(op_read, a_d, 64'd0, 1'b1);
		add_entry(op_read, a_e, 64'd0, 1'b1);
		add_entry(op_read, a_c, 64'd0, 1'b0);
		add_entry(op_read, a_b, 64'd0, 1'b0);
		add_entry(op_read, a_a, 64'd0, 1'b0);
		add_entry(op_read, line_addr(32'h0abc_0000, 8'h21, 3'd0), 64'd0, 1'b0);
	endtask

	// **************************************************
	// drive one entry and update the model
	// **************************************************

	task automatic apply_entry(input stim_t s);
		lc_cmd_t                c;
		lc_rsp_t                e;
		logic [`LC_TAG_W-1:0]   tag;
		logic [`LC_INDEX_W-1:0] idx;
		logic                   mis;
		logic                   mhit;
		tag = s.addr[`LC_ALEN-1 -: `LC_TAG_W];
		idx = s.addr[`LC_ALIGN_BITS +: `LC_INDEX_W];
		mis = (s.addr[`LC_ALIGN_BITS-1:0] != '0) && (s.op == op_read || s.op == op_write);
		c.op = s.op;
		c.addr = s.addr;
		c.wdata = s.data;
		cmd_valid <= 1'b1;
		cmd <= c;
		e = '0;
		e.valid = 1'b1;
		if (mis) begin
			e.error = 1'b1; // no hit, no data
			exp_q.push_back(e);
			issue_q.push_back(cyc);
		end else if (s.op == op_read) begin
			mhit = mdl_valid[idx] && (mdl_tag[idx] == tag);
			if (mhit != s.exp_hit) begin
				errors++;
				$display("stimulus table and model disagree on hit at cycle %0d", cyc);
			end
			if (mhit)
				n_hit++;
			else
				n_miss++;
			e.hit = s.exp_hit;
			e.rdata = mhit ? mdl_data[idx] : '0;
			exp_q.push_back(e);
			issue_q.push_back(cyc);
		end else if (s.op == op_write) begin
			mdl_valid[idx] = 1'b1;
			mdl_tag[idx] = tag;
			mdl_data[idx] = s.data;
		end else if (s.op == op_inval_all) begin
			for (int k = 0; k < n_lines; k++)
				mdl_valid[k] = 1'b0;
		end
	endtask

	// sampled at the falling edge, away from the DUT's register updates
	task automatic watch_rsp();
		lc_rsp_t e;
		int      t0;
		if (rsp.valid) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("response at cycle %0d arrived with no command waiting for it", cyc);
			end else begin
				e = exp_q.pop_front();
				t0 = issue_q.pop_front();
				check_val("rsp latency", 64'(3), 64'(cyc - t0));
				check_val("rsp.hit", 64'(e.hit), 64'(rsp.hit));
				check_val("rsp.error", 64'(e.error), 64'(rsp.error));
				check_val("rsp.rdata", e.rdata, rsp.rdata);
			end
		end else if (issue_q.size() != 0 && cyc - issue_q[0] > rsp_timeout) begin
			errors++;
			timed_out = 1'b1;
			$display("response for the command issued at cycle %0d timed out", issue_q[0]);
		end
	endtask

	// **************************************************
	// main sequence
	// **************************************************

	initial begin
		int i;
		int n;
		rst = 1'b1;
		cmd_valid = 1'b0;
		cmd = '0;
		errors = 0;
		n_checks = 0;
		n_hit = 0;
		n_miss = 0;
		cyc = 0;
		timed_out = 1'b0;
		lfsr_state = 32'hbb9561d8;
		for (int k = 0; k < n_lines; k++) begin
			mdl_valid[k] = 1'b0;
			mdl_tag[k] = '0;
			mdl_data[k] = '0;
		end
		build_table();
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		i = 0;
		while (i < tbl.size() && !timed_out) begin
			@(posedge clk);
			cyc++;
			apply_entry(tbl[i]);
			i++;
			@(negedge clk);
			watch_rsp();
		end
		n = 0;
		while (issue_q.size() != 0 && n < rsp_timeout && !timed_out) begin
			@(posedge clk);
			cyc++;
			cmd_valid <= 1'b0;
			@(negedge clk);
			watch_rsp();
			n++;
		end
		if (issue_q.size() != 0 && !timed_out) begin
			errors++;
			$display("responses still missing after the last command, wait timed out");
		end
		check_val("hit_count", 64'(n_hit), 64'(hit_count));
		check_val("miss_count", 64'(n_miss), 64'(miss_count));
		$display("checks %0d, errors %0d", n_checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

/* line_cache.f */
+incdir+src
src/line_cache_pkg.sv
src/cmd_decode.sv
src/line_bram.sv
src/basic_cache.sv
src/result_stage.sv
src/line_cache_top.sv
tests/line_cache_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the line cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --top-module line_cache_tb -f line_cache.f \
	-Mdir obj_dir -o line_cache_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "build failed"
	exit 1
fi

./obj_dir/line_cache_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Testbench failed" sim.log; then
	exit 1
fi
exit 0
